//--- hw/uart_pkg.sv
// UART link shared definitions
// Oversampling rate, frame state encoding and requester count used by the
// transmitter, receiver, arbiter and top level

package uart_pkg;

  // every bit on the line spans this many baud ticks
  // the tick counters in the transmitter and receiver are 4 bits wide
  localparam int oversample = 16;

  // number of peer requesters sharing the transmitter
  localparam int num_src = 2;

  // frame states, shared by the transmitter and the receiver
  typedef enum logic [2:0] {
    idle   = 3'd0, // line held high, waiting for work
    start  = 3'd1, // start bit, line low
    data   = 3'd2, // data bits, LSB first
    parity = 3'd3, // even parity bit
    stop   = 3'd4  // stop bit, line high
  } uart_state_t;

  // Frame layout on the line, one entry per bit time:
  //   start | d0 .. d(DATA_BITS-1) | parity | stop
  // so a frame is DATA_BITS+3 bits, each oversample ticks long.
  // Even parity means the parity bit equals the XOR of the data bits,
  // giving an even count of ones across data and parity together.

endpackage

//--- hw/baud_tick_gen.sv
// Baud tick generator
// Free-running divider that pulses tick for one clk cycle every BAUD_DIV
// cycles, giving 16 ticks per bit at the link's bit rate

`timescale 1ns/1ps

module baud_tick_gen #(
  parameter int BAUD_DIV = 4
) (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  localparam int cnt_w = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam logic [cnt_w-1:0] reload = cnt_w'(BAUD_DIV - 1);

  logic [cnt_w-1:0] cnt_q; // counts down to zero, then reloads

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt_q <= reload;
    end else begin
      if (cnt_q == '0) begin
        cnt_q <= reload; // wrap and start the next period
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // one cycle wide, once per BAUD_DIV cycles
  assign tick = (cnt_q == '0);

endmodule

//--- hw/uart_transmitter.sv
// UART transmitter, 16x oversampled
// Sends start, data LSB first, even parity and stop bits, each held for
// 16 baud ticks, and pulses tx_done on the last tick of the stop bit

`timescale 1ns/1ps

module uart_transmitter import uart_pkg::*; #(
  parameter int DATA_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tick,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] din,
  output logic                 tx,
  output logic                 tx_done
);

  localparam int cnt_w = $clog2(DATA_BITS);
  localparam logic [3:0]       tick_last = 4'(oversample - 1);
  localparam logic [cnt_w-1:0] bit_last  = cnt_w'(DATA_BITS - 1);

  uart_state_t          state_q;
  uart_state_t          state_d;
  logic [3:0]           tick_cnt_q; // ticks spent in the current bit
  logic [3:0]           tick_cnt_d;
  logic [cnt_w-1:0]     bit_cnt_q;  // data bits already sent
  logic [cnt_w-1:0]     bit_cnt_d;
  logic [DATA_BITS-1:0] shift_q;    // word being shifted out, bit 0 is on the line
  logic [DATA_BITS-1:0] shift_d;
  logic                 par_q;      // even parity of the latched word
  logic                 par_d;
  logic                 tx_q;       // registered line driver
  logic                 tx_d;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q    <= idle;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1; // idle line is high
    end else begin
      state_q    <= state_d;
      tick_cnt_q <= tick_cnt_d;
      bit_cnt_q  <= bit_cnt_d;
      tx_q       <= tx_d;
    end
  end

  always_ff @(posedge clk) begin
    shift_q <= shift_d;
    par_q   <= par_d;
  end

  // Each bit boundary also loads the next line level into tx_d, so the
  // registered tx changes on the same edge as the state does.
  always_comb begin
    state_d    = state_q;
    tick_cnt_d = tick_cnt_q;
    bit_cnt_d  = bit_cnt_q;
    shift_d    = shift_q;
    par_d      = par_q;
    tx_d       = tx_q;
    tx_done    = 1'b0;

    case (state_q)
      idle: begin
        if (tx_start) begin
          state_d    = start;
          tick_cnt_d = '0;
          bit_cnt_d  = '0;
          shift_d    = din;
          par_d      = ^din; // even parity
          tx_d       = 1'b0; // start bit goes out on the next cycle
        end
      end
      start: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            state_d    = data;
            tick_cnt_d = '0;
            tx_d       = shift_q[0];
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      data: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            tick_cnt_d = '0;
            shift_d    = shift_q >> 1;
            if (bit_cnt_q == bit_last) begin
              state_d = parity;
              tx_d    = par_q;
            end else begin
              bit_cnt_d = bit_cnt_q + 1'b1;
              tx_d      = shift_d[0];
            end
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      parity: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            state_d    = stop;
            tick_cnt_d = '0;
            tx_d       = 1'b1;
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      stop: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            state_d    = idle;
            tick_cnt_d = '0;
            tx_done    = 1'b1; // last cycle of the stop bit
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      default: state_d = idle;
    endcase
  end

  assign tx = tx_q;

endmodule

//--- hw/uart_receiver.sv
// UART receiver, 16x oversampled
// Synchronizes rx, arms on a falling edge, samples every bit at mid-bit and
// reports the word with even parity and stop bit checks

`timescale 1ns/1ps

module uart_receiver import uart_pkg::*; #(
  parameter int DATA_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tick,
  input  logic                 rx,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_parity_err,
  output logic                 rx_frame_err
);

  localparam int cnt_w = $clog2(DATA_BITS);
  localparam logic [3:0]       tick_mid  = 4'(oversample / 2 - 1);
  localparam logic [3:0]       tick_last = 4'(oversample - 1);
  localparam logic [cnt_w-1:0] bit_last  = cnt_w'(DATA_BITS - 1);

  logic [1:0]           sync_q;     // two-flop synchronizer, bit 1 is the safe copy
  logic                 rx_s;
  logic                 rx_prev_q;  // previous synchronized level for edge detect
  uart_state_t          state_q;
  uart_state_t          state_d;
  logic [3:0]           tick_cnt_q;
  logic [3:0]           tick_cnt_d;
  logic [cnt_w-1:0]     bit_cnt_q;
  logic [cnt_w-1:0]     bit_cnt_d;
  logic                 shift_en;   // sample a data bit this cycle
  logic                 par_en;     // sample the parity bit this cycle
  logic                 stop_en;    // sample the stop bit and report
  logic [DATA_BITS-1:0] shift_q;
  logic                 par_bit_q;
  logic [DATA_BITS-1:0] rx_data_q;
  logic                 rx_valid_q;
  logic                 parity_err_q;
  logic                 frame_err_q;

  assign rx_s = sync_q[1];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      sync_q       <= 2'b11; // line idles high
      rx_prev_q    <= 1'b1;
      state_q      <= idle;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      rx_valid_q   <= 1'b0;
      parity_err_q <= 1'b0;
      frame_err_q  <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx};
      rx_prev_q  <= rx_s;
      state_q    <= state_d;
      tick_cnt_q <= tick_cnt_d;
      bit_cnt_q  <= bit_cnt_d;
      rx_valid_q <= stop_en;
      if (stop_en) begin
        parity_err_q <= par_bit_q ^ (^shift_q); // flags hold until the next word
        frame_err_q  <= ~rx_s;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (shift_en) shift_q <= {rx_s, shift_q[DATA_BITS-1:1]}; // LSB arrives first
    if (par_en) par_bit_q <= rx_s;
    if (stop_en) rx_data_q <= shift_q;
  end

  always_comb begin
    state_d    = state_q;
    tick_cnt_d = tick_cnt_q;
    bit_cnt_d  = bit_cnt_q;
    shift_en   = 1'b0;
    par_en     = 1'b0;
    stop_en    = 1'b0;

    case (state_q)
      idle: begin
        if (rx_prev_q && !rx_s) begin // high-to-low edge arms the receiver
          state_d    = start;
          tick_cnt_d = '0;
        end
      end
      start: begin
        if (tick) begin
          if (tick_cnt_q == tick_mid) begin
            tick_cnt_d = '0;
            bit_cnt_d  = '0;
            // a glitch that is back high by mid-bit is dropped
            state_d    = rx_s ? idle : data;
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      data: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            tick_cnt_d = '0;
            shift_en   = 1'b1;
            if (bit_cnt_q == bit_last) state_d = parity;
            else bit_cnt_d = bit_cnt_q + 1'b1;
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      parity: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            tick_cnt_d = '0;
            par_en     = 1'b1;
            state_d    = stop;
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      stop: begin
        if (tick) begin
          if (tick_cnt_q == tick_last) begin
            tick_cnt_d = '0;
            stop_en    = 1'b1; // mid stop bit, half a bit before the sender ends
            state_d    = idle;
          end else begin
            tick_cnt_d = tick_cnt_q + 4'd1;
          end
        end
      end
      default: state_d = idle;
    endcase
  end

  assign rx_data       = rx_data_q;
  assign rx_valid      = rx_valid_q;
  assign rx_parity_err = parity_err_q;
  assign rx_frame_err  = frame_err_q;

endmodule

//--- hw/tx_arbiter.sv
// Round-robin arbiter for the shared UART transmitter
// Holds one word per requester, grants the transmitter to pending words in
// turn and returns a done pulse to the owner when its frame ends

`timescale 1ns/1ps

module tx_arbiter import uart_pkg::*; #(
  parameter int DATA_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_src-1:0]   req,
  input  logic [DATA_BITS-1:0] data_a,
  input  logic [DATA_BITS-1:0] data_b,
  output logic [num_src-1:0]   pending,
  output logic [num_src-1:0]   done,
  output logic                 tx_start,
  output logic [DATA_BITS-1:0] din,
  input  logic                 tx_done
);

  localparam int idx_w = $clog2(num_src);

  logic [DATA_BITS-1:0] src_data [num_src];
  logic [DATA_BITS-1:0] hold_q   [num_src]; // one held word per requester
  logic [num_src-1:0]   pending_q;
  logic [num_src-1:0]   done_q;
  logic                 busy_q;             // a frame is on the line
  logic [idx_w-1:0]     gnt_q;              // owner of the frame under way
  logic [idx_w-1:0]     last_q;             // last granted requester
  logic                 tx_start_q;
  logic [DATA_BITS-1:0] din_q;
  logic                 grant_ok;
  logic [idx_w-1:0]     grant_idx;
  logic                 frame_end;

  assign src_data[0] = data_a;
  assign src_data[1] = data_b;
  assign frame_end   = busy_q & tx_done;

  // search starts just after the last winner, so a tie goes to the other side
  always_comb begin
    logic [idx_w-1:0] cand;
    grant_ok  = 1'b0;
    grant_idx = last_q;
    for (int k = 1; k <= num_src; k++) begin
      cand = idx_w'((int'(last_q) + k) % num_src);
      if (!grant_ok && !busy_q && pending_q[cand]) begin
        grant_ok  = 1'b1;
        grant_idx = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pending_q  <= '0;
      done_q     <= '0;
      busy_q     <= 1'b0;
      gnt_q      <= '0;
      last_q     <= idx_w'(num_src - 1); // requester 0 wins the first tie
      tx_start_q <= 1'b0;
    end else begin
      tx_start_q <= grant_ok;
      done_q     <= '0;
      if (grant_ok) begin
        busy_q <= 1'b1;
        gnt_q  <= grant_idx;
        last_q <= grant_idx;
      end else if (frame_end) begin
        busy_q        <= 1'b0;
        done_q[gnt_q] <= 1'b1;
      end
      for (int i = 0; i < num_src; i++) begin
        if (req[i] && !pending_q[i]) pending_q[i] <= 1'b1; // strobes while pending are dropped
        else if (frame_end && gnt_q == idx_w'(i)) pending_q[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_src; i++) begin
      if (req[i] && !pending_q[i]) hold_q[i] <= src_data[i];
    end
    if (grant_ok) din_q <= hold_q[grant_idx];
  end

  assign pending  = pending_q;
  assign done     = done_q;
  assign tx_start = tx_start_q;
  assign din      = din_q;

endmodule

//--- hw/uart_link_top.sv
// Serial link top level
// Two requesters share one UART transmitter through a round-robin arbiter,
// and a matching receiver decodes the rx pin, both paced by one tick source

`timescale 1ns/1ps

module uart_link_top import uart_pkg::*; #(
  parameter int DATA_BITS = 8,
  parameter int BAUD_DIV  = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_src-1:0]   req,
  input  logic [DATA_BITS-1:0] data_a,
  input  logic [DATA_BITS-1:0] data_b,
  output logic [num_src-1:0]   pending,
  output logic [num_src-1:0]   done,
  output logic                 tx,
  input  logic                 rx,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_parity_err,
  output logic                 rx_frame_err
);

  logic                 tick;     // 16x bit-rate pulse shared by both directions
  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_din;
  logic                 tx_done;

  baud_tick_gen #(.BAUD_DIV(BAUD_DIV)) u_tick (
    .clk  (clk),
    .rst  (rst),
    .tick (tick)
  );

  tx_arbiter #(.DATA_BITS(DATA_BITS)) u_arb (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .data_a   (data_a),
    .data_b   (data_b),
    .pending  (pending),
    .done     (done),
    .tx_start (tx_start),
    .din      (tx_din),
    .tx_done  (tx_done)
  );

  uart_transmitter #(.DATA_BITS(DATA_BITS)) u_tx (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .tx_start (tx_start),
    .din      (tx_din),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_receiver #(.DATA_BITS(DATA_BITS)) u_rx (
    .clk           (clk),
    .rst           (rst),
    .tick          (tick),
    .rx            (rx),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

//--- verification/tb_uart_link.sv
// Testbench for the serial link top level
// Random words from two requesters go out on tx and loop back to rx through a
// stage that can corrupt the parity or stop bit, checked against a model

`timescale 1ns/1ps

module tb_uart_link import uart_pkg::*; ();

  localparam int DATA_BITS   = 8;
  localparam int BAUD_DIV    = 4;
  localparam int rst_cycles  = 16;
  localparam int frame_ticks = (DATA_BITS + 3) * oversample;
  localparam int num_frames  = 37;
  localparam int watchdog_ns = 2 * num_frames * frame_ticks * BAUD_DIV * 40;
  localparam int inj_none    = 0;
  localparam int inj_parity  = 1;
  localparam int inj_stop    = 2;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [num_src-1:0]   req;
  logic [DATA_BITS-1:0] data_a;
  logic [DATA_BITS-1:0] data_b;
  logic [num_src-1:0]   pending;
  logic [num_src-1:0]   done;
  logic                 tx;
  logic                 rx;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_parity_err;
  logic                 rx_frame_err;

  logic [16:0]          lfsr_q = 17'd95452;
  logic                 flip = 1'b0;      // inverts the line during the parity bit
  logic                 force_low = 1'b0; // pulls the line low during the stop bit
  int                   inj_mode = 0;     // corruption for the next frame on the line
  logic                 first_req = 1'b0;
  int                   edge_n = 0;
  logic                 line_on = 1'b0;
  int                   line_ticks;
  int                   line_inj;
  int                   bit_now;
  logic                 tick_now;

  // model state
  logic [DATA_BITS-1:0] held [num_src];   // word each requester has handed over
  logic [DATA_BITS-1:0] exp_word [$];
  int                   exp_inj [$];
  int                   done_src [$];
  logic                 m_busy = 1'b0;
  int                   m_last = 1;       // requester 0 wins the first tie
  int                   frames_done = 0;
  int                   ncyc = 0;
  logic                 frame_on = 1'b0;
  logic                 run_on = 1'b0;
  int                   fall_cyc;
  int                   low_run;
  int                   src;
  int                   kind;
  int                   len;
  logic [DATA_BITS-1:0] w;

  always #20 clk = ~clk;

  assign rx = (tx ^ flip) & ~force_low; // loopback through the corruption stage

  uart_link_top #(.DATA_BITS(DATA_BITS), .BAUD_DIV(BAUD_DIV)) u_dut (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .data_a        (data_a),
    .data_b        (data_b),
    .pending       (pending),
    .done          (done),
    .tx            (tx),
    .rx            (rx),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  // 17-bit Fibonacci LFSR, taps 17 and 14, one step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[16] ^ lfsr_q[13];
      lfsr_q = {lfsr_q[15:0], fb};
      v      = {v[6:0], fb};
    end
    return v;
  endfunction

  task automatic report_fail();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_req(input logic [1:0] which, input logic [7:0] wa,
                           input logic [7:0] wb);
    first_req = 1'b1;
    if (which[0] && !pending[0]) held[0] = wa; // a strobe while pending keeps the old word
    if (which[1] && !pending[1]) held[1] = wb;
    req    = which;
    data_a = wa;
    data_b = wb;
    step_cycle();
    req = '0;
  endtask

  task automatic wait_idle();
    step_cycle();
    while (pending !== '0 || done_src.size() != 0) step_cycle();
    repeat (4) step_cycle();
  endtask

  // corruption stage, paced by a copy of the free-running tick phase
  always @(posedge clk) begin
    edge_n++;
    #2;
    tick_now = (edge_n > rst_cycles) && ((edge_n - rst_cycles) % BAUD_DIV == BAUD_DIV - 1);
    if (!line_on && !tx) begin
      line_on    = 1'b1; // the frame starts with the falling edge of tx
      line_ticks = 0;
      line_inj   = inj_mode;
    end
    if (line_on) begin
      bit_now   = line_ticks / oversample;
      flip      = (line_inj == inj_parity) && (bit_now == DATA_BITS + 1);
      force_low = (line_inj == inj_stop) && (bit_now == DATA_BITS + 2);
      if (tick_now) line_ticks++;
      if (line_ticks == frame_ticks) line_on = 1'b0;
    end else begin
      flip      = 1'b0;
      force_low = 1'b0;
    end
  end

  // outputs are sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (!first_req) begin
      assert (tx === 1'b1 && pending === '0 && done === '0 && rx_valid === 1'b0 &&
              rx_parity_err === 1'b0 && rx_frame_err === 1'b0) else begin
        $display("[ERROR] idle outputs: tx=0x%0h pending=0x%0h done=0x%0h rx_valid=0x%0h",
                 tx, pending, done, rx_valid);
        report_fail();
      end
    end
    if (rst) begin
      ncyc++;
      if (!frame_on && !tx) begin
        frame_on = 1'b1;
        run_on   = 1'b1;
        fall_cyc = ncyc;
        low_run  = 0;
      end
      if (run_on) begin
        if (!tx) low_run++;
        else begin
          run_on = 1'b0;
          // only a frame whose bit 0 is high shows the start bit alone
          if (exp_word.size() > 0 && exp_word[0][0]) begin
            assert (low_run >= 15 * BAUD_DIV + 1 && low_run <= 16 * BAUD_DIV) else begin
              $display("[ERROR] tx start bit: got 0x%0h cycles expected 0x%0h to 0x%0h",
                       low_run, 15 * BAUD_DIV + 1, 16 * BAUD_DIV);
              report_fail();
            end
          end
        end
      end
      if (rx_valid) begin
        assert (exp_word.size() > 0) else begin
          $display("rx_valid pulsed while no frame was expected");
          report_fail();
        end
        w    = exp_word.pop_front();
        kind = exp_inj.pop_front();
        assert (rx_data === w) else begin
          $display("[ERROR] rx_data: got 0x%0h expected 0x%0h", rx_data, w);
          report_fail();
        end
        assert (rx_parity_err === (kind == inj_parity)) else begin
          $display("[ERROR] rx_parity_err: got 0x%0h expected 0x%0h",
                   rx_parity_err, kind == inj_parity);
          report_fail();
        end
        assert (rx_frame_err === (kind == inj_stop)) else begin
          $display("[ERROR] rx_frame_err: got 0x%0h expected 0x%0h",
                   rx_frame_err, kind == inj_stop);
          report_fail();
        end
      end
      if (done !== '0) begin
        assert (done_src.size() > 0) else begin
          $display("done pulsed while no frame was under way");
          report_fail();
        end
        src = done_src.pop_front();
        len = ncyc - fall_cyc;
        assert (done === 2'(1 << src) && pending[src] === 1'b0) else begin
          $display("[ERROR] done: got 0x%0h expected 0x%0h, pending 0x%0h",
                   done, 2'(1 << src), pending);
          report_fail();
        end
        assert (len > (frame_ticks - 1) * BAUD_DIV && len <= frame_ticks * BAUD_DIV) else begin
          $display("[ERROR] frame length: got 0x%0h cycles expected 0x%0h to 0x%0h",
                   len, (frame_ticks - 1) * BAUD_DIV + 1, frame_ticks * BAUD_DIV);
          report_fail();
        end
        frame_on = 1'b0;
        m_busy   = 1'b0;
        frames_done++;
      end
      // grant rule: a single pending word wins, a tie goes to the one not served last
      if (!m_busy && pending != '0) begin
        if (pending[0] && pending[1]) src = 1 - m_last;
        else src = pending[1] ? 1 : 0;
        m_last = src;
        m_busy = 1'b1;
        exp_word.push_back(held[src]);
        exp_inj.push_back(inj_mode);
        done_src.push_back(src);
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the frames did not all complete in time");
    report_fail();
  end

  initial begin
    logic [7:0] wa;
    logic [7:0] wb;
    logic [7:0] pick;
    int         target;
    rst    = 1'b0;
    req    = '0;
    data_a = '0;
    data_b = '0;
    repeat (rst_cycles) @(posedge clk);
    #2;
    rst = 1'b1;
    repeat (8) step_cycle(); // nothing may move before the first request
    repeat (8) begin         // both requesters at once, alternation from requester 0
      wa = rand_bits(DATA_BITS);
      wb = rand_bits(DATA_BITS);
      drive_req(2'b11, wa, wb);
      wait_idle();
    end
    for (int i = 0; i < 4; i++) begin
      wa = rand_bits(DATA_BITS);
      drive_req(2'(1 << (i % 2)), wa, wa);
      wait_idle();
    end
    wa = rand_bits(DATA_BITS);
    wb = ~wa;
    drive_req(2'b10, wa, wa);
    drive_req(2'b10, wb, wb); // arrives while pending, must be dropped
    wait_idle();
    inj_mode = inj_stop;
    drive_req(2'b10, '0, rand_bits(DATA_BITS));
    wait_idle();
    inj_mode = inj_parity;
    drive_req(2'b01, rand_bits(DATA_BITS), '0);
    wait_idle();
    inj_mode = inj_none;
    // requester 0 was served last, so requester 1 takes this tie
    drive_req(2'b11, rand_bits(DATA_BITS), rand_bits(DATA_BITS));
    wait_idle();
    target = frames_done + 10;
    while (frames_done < target) begin
      pick = rand_bits(2);
      wa   = rand_bits(DATA_BITS);
      wb   = rand_bits(DATA_BITS);
      drive_req(pick[1:0], wa, wb);
    end
    wait_idle();
    assert (exp_word.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("received fewer words than were sent");
      report_fail();
    end
  end

endmodule

//--- flist.f
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_transmitter.sv
hw/uart_receiver.sv
hw/tx_arbiter.sv
hw/uart_link_top.sv
verification/tb_uart_link.sv
